/* bench/pkt_switch_tb.sv */
`timescale 1ns/100ps

module pkt_switch_tb;
    import switch_pkg::*;

    localparam int N_PORTS  = 4;
    localparam int DEPTH    = 64;
    localparam int WAIT_MAX = 2000;

    logic        clk;
    logic        arst_n;
    in_stream_t  in_links [N_PORTS];
    out_stream_t out_link;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    int          errors;
    int          timeouts;
    integer      seed;
    logic        en_shadow;
    logic [15:0] mask_shadow;
    int          fwd_model;
    int          drop_model;
    logic [15:0] pkt_buf [N_PORTS][$];
    out_stream_t exp_q [$];
    out_stream_t exp_head;
    logic        exp_avail;
    logic [1:0]  fwd_grant_d;
    logic        mid_pkt;

    always #5 clk = ~clk;

    pkt_switch #(
        .NUM_PORTS(N_PORTS),
        .BUF_DEPTH(DEPTH)
    ) DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_links (in_links),
        .out_link (out_link),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready)
    );

    // retire the word checked on the last falling edge
    always @(posedge clk) begin
        if (out_link.vld && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        exp_avail = exp_q.size() > 0;
        if (exp_avail) begin
            exp_head = exp_q[0];
        end
        fwd_grant_d <= {fwd_grant_d[0], (|DUT.grant) && DUT.fwd};
        if (!arst_n) begin
            mid_pkt <= 1'b0;
        end else if (out_link.vld) begin
            mid_pkt <= !out_link.eop;
        end
    end

    a_word_expected: assert property (
        @(negedge clk) disable iff (!arst_n) out_link.vld |-> exp_avail
    ) else begin
        errors++;
        $display("** Error at %0d ns: out_link.vld expected 0 got 1", $time);
    end

    a_data: assert property (
        @(negedge clk) disable iff (!arst_n)
        out_link.vld && exp_avail |-> out_link.data == exp_head.data
    ) else begin
        errors++;
        $display("** Error at %0d ns: out_link.data expected %h got %h",
                 $time, exp_head.data, out_link.data);
    end

    a_src: assert property (
        @(negedge clk) disable iff (!arst_n)
        out_link.vld && exp_avail |-> out_link.src == exp_head.src
    ) else begin
        errors++;
        $display("** Error at %0d ns: out_link.src expected %0d got %0d",
                 $time, exp_head.src, out_link.src);
    end

    a_framing: assert property (
        @(negedge clk) disable iff (!arst_n)
        out_link.vld && exp_avail |-> {out_link.sop, out_link.eop} == {exp_head.sop, exp_head.eop}
    ) else begin
        errors++;
        $display("** Error at %0d ns: out_link.sop/eop expected %b%b got %b%b",
                 $time, exp_head.sop, exp_head.eop, out_link.sop, out_link.eop);
    end

    // sop two cycles after a forwarding grant
    a_grant_to_sop: assert property (
        @(negedge clk) disable iff (!arst_n)
        fwd_grant_d[1] == (out_link.vld && out_link.sop)
    ) else begin
        errors++;
        $display("** Error at %0d ns: out_link.sop expected %b got %b",
                 $time, fwd_grant_d[1], out_link.vld && out_link.sop);
    end

    a_unbroken: assert property (
        @(negedge clk) disable iff (!arst_n) mid_pkt |-> out_link.vld
    ) else begin
        errors++;
        $display("** Error at %0d ns: out_link.vld expected 1 got 0", $time);
    end

    task automatic end_run();
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
        end_run();
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        psel   = 1'b1;
        pwrite = write;
        paddr  = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!pready) begin
            waited++;
            if (waited > WAIT_MAX) begin
                abort_on_timeout("APB pready");
            end
            @(posedge clk);
        end
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused_rd;
        apb_transfer(1'b1, addr, data, unused_rd);
        if (addr == REG_CTRL) begin
            en_shadow = data[0];
        end
        if (addr == REG_DEST_MASK) begin
            mask_shadow = data[15:0];
        end
    endtask

    task automatic check_reg(input logic [11:0] addr, input logic [31:0] expected,
                             input string name);
        logic [31:0] rdata;
        apb_transfer(1'b0, addr, 32'd0, rdata);
        assert (rdata == expected) else begin
            errors++;
            $display("** Error at %0d ns: prdata %s expected %h got %h",
                     $time, name, expected, rdata);
        end
    endtask

    function automatic int rand_len();
        return 2 + int'($random(seed) & 32'h0000_000F);
    endfunction

    task automatic build_packet(input int port, input logic [2:0] prior,
                                input logic [3:0] dest, input int len);
        pkt_hdr_t hdr;
        hdr.length    = 9'(len);
        hdr.prior     = prior;
        hdr.dest_port = dest;
        pkt_buf[port].delete();
        pkt_buf[port].push_back(hdr);
        for (int i = 1; i < len; i++) begin
            pkt_buf[port].push_back(16'($random(seed)));
        end
    endtask

    // forward only when enabled and the destination is in the mask
    task automatic expect_packet(input int port, input logic [3:0] dest);
        out_stream_t word;
        int          n;
        n = pkt_buf[port].size();
        if (en_shadow && mask_shadow[dest]) begin
            fwd_model++;
            for (int i = 0; i < n; i++) begin
                word.vld  = 1'b1;
                word.sop  = (i == 0);
                word.eop  = (i == n - 1);
                word.src  = PORT_W'(port);
                word.data = pkt_buf[port][i];
                exp_q.push_back(word);
            end
        end else begin
            drop_model++;
        end
    endtask

    task automatic drive_packet(input int port);
        int n;
        n = pkt_buf[port].size();
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            in_links[port].sop  = (i == 0);
            in_links[port].eop  = (i == n - 1);
            in_links[port].vld  = 1'b1;
            in_links[port].data = pkt_buf[port][i];
        end
        @(negedge clk);
        in_links[port] = '0;
    endtask

    // output drained and every expected drop counted
    task automatic wait_settled();
        logic [31:0] drops;
        int          tries;
        tries = 0;
        drops = 32'(drop_model - 1);
        while (exp_q.size() != 0 || out_link.vld || drops < 32'(drop_model)) begin
            tries++;
            if (tries > WAIT_MAX) begin
                abort_on_timeout("output drain and drop count");
            end
            apb_transfer(1'b0, REG_DROP_CNT, 32'd0, drops);
        end
    endtask

    task automatic send_packet(input int port, input logic [2:0] prior,
                               input logic [3:0] dest, input int len);
        build_packet(port, prior, dest, len);
        expect_packet(port, dest);
        drive_packet(port);
        wait_settled();
    endtask

    // both pending together, higher prior first, then lower index
    task automatic send_pair(input int pa, input logic [2:0] prior_a,
                             input int pb, input logic [2:0] prior_b);
        build_packet(pa, prior_a, 4'd0, rand_len());
        build_packet(pb, prior_b, 4'd0, rand_len());
        if (prior_b > prior_a || (prior_b == prior_a && pb < pa)) begin
            expect_packet(pb, 4'd0);
            expect_packet(pa, 4'd0);
        end else begin
            expect_packet(pa, 4'd0);
            expect_packet(pb, 4'd0);
        end
        fork
            drive_packet(pa);
            drive_packet(pb);
        join
        wait_settled();
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        for (int i = 0; i < N_PORTS; i++) begin
            in_links[i] = '0;
        end
        seed        = 32'ha9c11273;
        errors      = 0;
        timeouts    = 0;
        en_shadow   = 1'b0;
        mask_shadow = 16'hFFFF;
        fwd_model   = 0;
        drop_model  = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_reg(REG_CTRL, 32'd0, "CTRL");
        check_reg(REG_DEST_MASK, 32'h0000_FFFF, "DEST_MASK");
        reg_write(REG_DEST_MASK, 32'h0000_5A3C);
        check_reg(REG_DEST_MASK, 32'h0000_5A3C, "DEST_MASK");
        reg_write(REG_CTRL, 32'd1);
        check_reg(REG_CTRL, 32'd1, "CTRL");
        check_reg(12'h010, 32'd0, "unmapped 0x010");
        reg_write(REG_DEST_MASK, 32'h0000_FFFF);

        send_packet(1, 3'd3, 4'd5, rand_len());

        send_pair(0, 3'd2, 2, 3'd6);
        send_pair(3, 3'd4, 1, 3'd4);

        // masked destination
        reg_write(REG_DEST_MASK, 32'h0000_FDFF);
        send_packet(2, 3'd1, 4'd9, rand_len());
        send_packet(2, 3'd1, 4'd4, rand_len());
        check_reg(REG_DROP_CNT, 32'(drop_model), "DROP_CNT");
        reg_write(REG_DEST_MASK, 32'h0000_FFFF);

        reg_write(REG_CTRL, 32'd0);
        for (int p = 0; p < N_PORTS; p++) begin
            send_packet(p, 3'($random(seed)), 4'(p * 3), rand_len());
        end
        reg_write(REG_CTRL, 32'd1);
        for (int p = 0; p < N_PORTS; p++) begin
            send_packet(p, 3'($random(seed)), 4'(p * 3), rand_len());
        end
        check_reg(REG_FWD_CNT, 32'(fwd_model), "FWD_CNT");
        check_reg(REG_DROP_CNT, 32'(drop_model), "DROP_CNT");

        // grant lands while the packet is still arriving
        send_packet(3, 3'd5, 4'd7, 40);

        for (int k = 0; k < 4; k++) begin
            send_pair(k, 3'($random(seed)), (k + 1) % N_PORTS, 3'($random(seed)));
        end
        check_reg(REG_FWD_CNT, 32'(fwd_model), "FWD_CNT");

        wait_settled();
        end_run();
    end

endmodule

/* pkt_switch.f */
source/switch_pkg.sv
source/ingress_port.sv
source/port_search.sv
source/egress_mux.sv
source/switch_regs.sv
source/pkt_switch.sv
bench/pkt_switch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the packet switch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module pkt_switch_tb \
    -f pkt_switch.f \
    -o pkt_switch_sim

./obj_dir/pkt_switch_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

/* source/egress_mux.sv */
`timescale 1ns/100ps

module egress_mux #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  switch_pkg::out_stream_t ins [NUM_PORTS],
    output switch_pkg::out_stream_t out,
    output logic                    busy
);
    import switch_pkg::*;

    out_stream_t          merged;
    logic [NUM_PORTS-1:0] vld_vec;
    logic                 out_vld;
    logic                 out_sop;
    logic                 out_eop;
    logic [PORT_W-1:0]    out_src;
    logic [DATA_W-1:0]    out_data;
    logic                 busy_r;

    // only one port replays at a time, idle ports are masked off
    always_comb begin
        merged = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            vld_vec[i] = ins[i].vld;
            if (ins[i].vld) begin
                merged = out_stream_t'(merged | ins[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld <= 1'b0;
            out_sop <= 1'b0;
            out_eop <= 1'b0;
            busy_r  <= 1'b0;
        end else begin
            out_vld <= merged.vld;
            out_sop <= merged.sop;
            out_eop <= merged.eop;
            if (out_vld && out_eop) begin
                busy_r <= 1'b0;
            end else if (out_vld && out_sop) begin
                busy_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        out_src  <= merged.src;
        out_data <= merged.data;
    end

    // high from the output sop through the output eop
    assign busy = busy_r || out_vld;

    assign out.vld  = out_vld;
    assign out.sop  = out_sop;
    assign out.eop  = out_eop;
    assign out.src  = out_src;
    assign out.data = out_data;

    a_one_port_valid: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(vld_vec)
    ) else $error("more than one port drives the output");

endmodule

/* source/ingress_port.sv */
`timescale 1ns/100ps

module ingress_port #(
    parameter int BUF_DEPTH = switch_pkg::BUF_DEPTH
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  switch_pkg::in_stream_t        in,
    output switch_pkg::hdr_req_t          req,
    input  logic                          grant,
    input  logic                          fwd,
    output switch_pkg::out_stream_t       out,
    input  logic [switch_pkg::PORT_W-1:0] src_id
);
    import switch_pkg::*;

    localparam int AW = $clog2(BUF_DEPTH);

    logic [DATA_W-1:0] mem [BUF_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW-1:0]     end_ptr;
    logic [AW-1:0]     ahead;
    hdr_word_u         in_word;
    pkt_hdr_t          hdr_q;
    logic              hdr_next;
    logic              held;
    logic              wr_done;
    logic              pending;
    logic              replay;
    logic              discard;
    logic              started;
    logic              is_hdr;
    logic              rd_avail;
    logic              rd_en;
    logic              rd_last;
    logic              finish;
    logic              out_vld;
    logic              out_sop;
    logic              out_eop;
    logic [DATA_W-1:0] out_data;

    assign in_word.raw = in.data;

    // header is the first valid word at or after sop
    assign is_hdr = in.vld && (in.sop || hdr_next);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdr_next <= 1'b0;
        end else if (in.vld) begin
            hdr_next <= 1'b0;
        end else if (in.sop) begin
            hdr_next <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (in.vld) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in.vld) begin
            mem[wr_ptr] <= in_word.raw;
        end
        if (is_hdr) begin
            hdr_q <= in_word.hdr;
        end
        // eop may come with the last word or on the cycle after it
        if (in.eop) begin
            end_ptr <= in.vld ? wr_ptr : wr_ptr - 1'b1;
        end
        if (rd_en) begin
            out_data <= mem[rd_ptr];
        end
    end

    assign ahead = wr_ptr - rd_ptr;

    // newest word waits until eop says whether it is the last one
    assign rd_avail = wr_done || (ahead > AW'(1));
    assign rd_en    = (replay || (grant && fwd)) && rd_avail;
    assign rd_last  = rd_en && wr_done && (rd_ptr == end_ptr);
    assign finish   = rd_last || (discard && wr_done);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr  <= '0;
            held    <= 1'b0;
            wr_done <= 1'b0;
            pending <= 1'b0;
            replay  <= 1'b0;
            discard <= 1'b0;
            started <= 1'b0;
        end else begin
            if (is_hdr) begin
                rd_ptr <= wr_ptr;
            end else if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (is_hdr) begin
                held <= 1'b1;
            end else if (finish) begin
                held <= 1'b0;
            end
            if (in.eop) begin
                wr_done <= 1'b1;
            end else if (finish) begin
                wr_done <= 1'b0;
            end
            if (is_hdr) begin
                pending <= 1'b1;
            end else if (grant) begin
                pending <= 1'b0;
            end
            if (rd_last) begin
                replay <= 1'b0;
            end else if (grant && fwd) begin
                replay <= 1'b1;
            end
            if (finish) begin
                discard <= 1'b0;
            end else if (grant && !fwd) begin
                discard <= 1'b1;
            end
            if (finish) begin
                started <= 1'b0;
            end else if (rd_en) begin
                started <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld <= 1'b0;
            out_sop <= 1'b0;
            out_eop <= 1'b0;
        end else begin
            out_vld <= rd_en;
            out_sop <= rd_en && !started;
            out_eop <= rd_last;
        end
    end

    assign req.pending = pending;
    assign req.hdr     = hdr_q;

    assign out.vld  = out_vld;
    assign out.sop  = out_sop;
    assign out.eop  = out_eop;
    assign out.src  = src_id;
    assign out.data = out_data;

    // source must wait until the previous packet has left
    a_no_sop_while_held: assert property (
        @(posedge clk) disable iff (!arst_n) in.sop |-> !held
    ) else $error("sop on a port that still holds a packet");

endmodule

/* source/pkt_switch.sv */
`timescale 1ns/100ps

module pkt_switch #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS,
    parameter int BUF_DEPTH = switch_pkg::BUF_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  switch_pkg::in_stream_t  in_links [NUM_PORTS],
    output switch_pkg::out_stream_t out_link,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [11:0]             paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready
);
    import switch_pkg::*;

    hdr_req_t             reqs [NUM_PORTS];
    out_stream_t          port_out [NUM_PORTS];
    logic [NUM_PORTS-1:0] grant;
    logic                 fwd;
    logic                 fwd_evt;
    logic                 drop_evt;
    logic                 out_busy;
    logic                 enable;
    logic [15:0]          dest_mask;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        ingress_port #(
            .BUF_DEPTH(BUF_DEPTH)
        ) u_port (
            .clk    (clk),
            .arst_n (arst_n),
            .in     (in_links[i]),
            .req    (reqs[i]),
            .grant  (grant[i]),
            .fwd    (fwd),
            .out    (port_out[i]),
            .src_id (PORT_W'(i))
        );
    end

    port_search #(
        .NUM_PORTS(NUM_PORTS)
    ) u_search (
        .clk       (clk),
        .arst_n    (arst_n),
        .reqs      (reqs),
        .out_busy  (out_busy),
        .enable    (enable),
        .dest_mask (dest_mask),
        .grant     (grant),
        .fwd       (fwd),
        .fwd_evt   (fwd_evt),
        .drop_evt  (drop_evt)
    );

    egress_mux #(
        .NUM_PORTS(NUM_PORTS)
    ) u_mux (
        .clk    (clk),
        .arst_n (arst_n),
        .ins    (port_out),
        .out    (out_link),
        .busy   (out_busy)
    );

    switch_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .fwd_evt   (fwd_evt),
        .drop_evt  (drop_evt),
        .enable    (enable),
        .dest_mask (dest_mask)
    );

endmodule

/* source/port_search.sv */
`timescale 1ns/100ps

module port_search #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  switch_pkg::hdr_req_t reqs [NUM_PORTS],
    input  logic                 out_busy,
    input  logic                 enable,
    input  logic [15:0]          dest_mask,
    output logic [NUM_PORTS-1:0] grant,
    output logic                 fwd,
    output logic                 fwd_evt,
    output logic                 drop_evt
);
    import switch_pkg::*;

    logic              found;
    logic [PORT_W-1:0] win_idx;
    pkt_hdr_t          win_hdr;
    logic              pass;
    logic              issue;
    logic              serving;
    logic              busy_q;

    // strict compare keeps the lowest index on equal prior
    always_comb begin
        found   = 1'b0;
        win_idx = '0;
        win_hdr = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (reqs[i].pending && (!found || reqs[i].hdr.prior > win_hdr.prior)) begin
                found   = 1'b1;
                win_idx = PORT_W'(i);
                win_hdr = reqs[i].hdr;
            end
        end
    end

    assign pass  = enable && dest_mask[win_hdr.dest_port];
    assign issue = found && !serving && !out_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant    <= '0;
            fwd      <= 1'b0;
            fwd_evt  <= 1'b0;
            drop_evt <= 1'b0;
            serving  <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            busy_q   <= out_busy;
            grant    <= '0;
            fwd_evt  <= 1'b0;
            drop_evt <= 1'b0;
            if (issue) begin
                grant[win_idx] <= 1'b1;
                fwd            <= pass;
                fwd_evt        <= pass;
                drop_evt       <= !pass;
                serving        <= 1'b1;
            end else if (serving) begin
                // a drop frees the search at once, a forward once the output goes idle
                if ((|grant && !fwd) || (busy_q && !out_busy)) begin
                    serving <= 1'b0;
                end
            end
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(grant)
    ) else $error("grant is not one-hot");

    a_no_grant_busy: assert property (
        @(posedge clk) disable iff (!arst_n) (|grant) |-> !out_busy
    ) else $error("grant issued while the output is busy");

endmodule

/* source/switch_pkg.sv */
package switch_pkg;

    // defaults only, the top level passes its own values down
    localparam int NUM_PORTS = 4;
    localparam int BUF_DEPTH = 64;

    localparam int PORT_W = 2;
    localparam int DATA_W = 16;

    // header word, dest_port sits in the low nibble
    typedef struct packed {
        logic [8:0] length;
        logic [2:0] prior;
        logic [3:0] dest_port;
    } pkt_hdr_t;

    // first word of a packet is stored raw and decoded as a header
    typedef union packed {
        logic [DATA_W-1:0] raw;
        pkt_hdr_t          hdr;
    } hdr_word_u;

    typedef struct packed {
        logic              sop;
        logic              eop;
        logic              vld;
        logic [DATA_W-1:0] data;
    } in_stream_t;

    typedef struct packed {
        logic              vld;
        logic              sop;
        logic              eop;
        logic [PORT_W-1:0] src;
        logic [DATA_W-1:0] data;
    } out_stream_t;

    // announcement from a port to the search unit
    typedef struct packed {
        logic     pending;
        pkt_hdr_t hdr;
    } hdr_req_t;

    // APB register map
    localparam logic [11:0] REG_CTRL      = 12'h000;
    localparam logic [11:0] REG_DEST_MASK = 12'h004;
    localparam logic [11:0] REG_FWD_CNT   = 12'h008;
    localparam logic [11:0] REG_DROP_CNT  = 12'h00C;

endpackage

/* source/switch_regs.sv */
`timescale 1ns/100ps

module switch_regs (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    input  logic        fwd_evt,
    input  logic        drop_evt,
    output logic        enable,
    output logic [15:0] dest_mask
);
    import switch_pkg::*;

    logic        wr_en;
    logic [31:0] fwd_cnt;
    logic [31:0] drop_cnt;

    // counters stick at all ones
    function automatic logic [31:0] sat_inc(input logic [31:0] value);
        return (&value) ? value : value + 32'd1;
    endfunction

    // no wait states
    assign pready = 1'b1;
    assign wr_en  = psel && penable && pwrite;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable    <= 1'b0;
            dest_mask <= 16'hFFFF;
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL: begin
                    enable <= pwdata[0];
                end
                REG_DEST_MASK: begin
                    dest_mask <= pwdata[15:0];
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            if (fwd_evt) begin
                fwd_cnt <= sat_inc(fwd_cnt);
            end
            if (drop_evt) begin
                drop_cnt <= sat_inc(drop_cnt);
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_CTRL:      prdata = {31'd0, enable};
                REG_DEST_MASK: prdata = {16'd0, dest_mask};
                REG_FWD_CNT:   prdata = fwd_cnt;
                REG_DROP_CNT:  prdata = drop_cnt;
                default:       prdata = '0;
            endcase
        end
    end

    // one decision per grant
    a_single_event: assert property (
        @(posedge clk) disable iff (!arst_n) !(fwd_evt && drop_evt)
    ) else $error("forward and drop reported together");

endmodule
